/* vlog.f */
+incdir+testbench
logic/local_mem_pkg.sv
logic/local_mem.sv
logic/io_bus_responder.sv
logic/data_request_router.sv
logic/local_mem_system.sv
testbench/local_mem_system_tb.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= local_mem_system_tb
RTL_TOP   ?= local_mem_system
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Result: FAILED
PASS_MSG  ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FLIST) --top-module $(TB_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/local_mem_system_tb_tasks.svh */
`ifndef LOCAL_MEM_SYSTEM_TB_TASKS_SVH
`define LOCAL_MEM_SYSTEM_TB_TASKS_SVH

// word compare, used for data and fetch results
task automatic check_word(input string name, input local_mem_pkg::data_addr_t addr,
                          input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        $display("FAIL %s addr %h expected %h actual %h", name, addr, exp, act);
        value_errors++;
    end
endtask

// uart byte compare
task automatic check_uart(input string name, input local_mem_pkg::data_addr_t addr,
                          input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        $display("FAIL %s uart addr %h expected %h actual %h", name, addr, exp, act);
        value_errors++;
    end
endtask

// response latency in cycles after acceptance
task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
        $display("FAIL %s latency expected %0d actual %0d", name, exp, act);
        value_errors++;
    end
endtask

// drive one data request, return just after the accepting edge
task automatic send_data(input local_mem_pkg::data_addr_t addr, input logic rnw,
                         input logic [3:0] be, input logic [31:0] wdata, output bit ok);
    int waited;
    @(negedge clk);
    req_valid = 1'b1;
    req_addr  = addr;
    req_rnw   = rnw;
    req_be    = be;
    req_wdata = wdata;
    waited    = 0;
    ok        = 1'b0;
    while (!ok && waited < TIMEOUT) begin
        // settle combinational ready
        #1;
        if (req_ready) begin
            ok = 1'b1;
        end else begin
            @(negedge clk);
            waited++;
        end
    end
    if (ok) begin
        @(posedge clk);
    end else begin
        $display("timeout: data request to %h was never accepted", addr);
        timeout_errors++;
        req_valid = 1'b0;
    end
endtask

// count negedges until resp_valid, also watch the uart strobe
task automatic wait_resp(input bit is_io, output int cycles, output logic [31:0] data,
                         output bit got, output bit uart_seen, output logic [7:0] ub);
    cycles    = 0;
    got       = 1'b0;
    uart_seen = 1'b0;
    data      = '0;
    ub        = '0;
    while (!got && cycles < TIMEOUT) begin
        @(negedge clk);
        cycles++;
        req_valid = 1'b0;
        if (write_uart) begin
            uart_seen = 1'b1;
            ub        = uart_byte;
        end
        if (resp_valid) begin
            got  = 1'b1;
            data = resp_rdata;
        end else if (is_io && req_ready) begin
            $display("req_ready went high while an io request was still pending");
            protocol_errors++;
        end
    end
    if (!got) begin
        $display("timeout: no data response arrived");
        timeout_errors++;
    end
endtask

// single fetch, data due one cycle after acceptance
task automatic do_fetch(input string name, input local_mem_pkg::data_addr_t addr,
                        input logic [31:0] exp);
    int waited;
    @(negedge clk);
    fetch_valid = 1'b1;
    fetch_addr  = addr;
    waited      = 0;
    #1;
    while (!fetch_ready && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
        #1;
    end
    if (!fetch_ready) begin
        $display("timeout: fetch of %h was never accepted", addr);
        timeout_errors++;
        fetch_valid = 1'b0;
    end else begin
        @(posedge clk);
        @(negedge clk);
        fetch_valid = 1'b0;
        if (!fetch_rvalid) begin
            $display("%s: fetch data did not arrive one cycle after acceptance", name);
            protocol_errors++;
        end else begin
            check_word(name, addr, exp, fetch_rdata);
        end
    end
endtask

`endif

/* testbench/local_mem_system_tb.sv */
`timescale 1ns/1ps

module local_mem_system_tb;

    localparam int TIMEOUT = 50;

    typedef enum {K_FETCH, K_READ, K_WRITE, K_IO_READ, K_IO_WRITE} kind_t;

    typedef struct {
        string                     name;
        kind_t                     kind;
        local_mem_pkg::data_addr_t addr;
        logic [3:0]                be;
        logic [31:0]               wdata;
        logic [31:0]               exp_word;
    } entry_t;

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    logic        fetch_ready;
    local_mem_pkg::data_addr_t fetch_addr;
    logic        fetch_rvalid;
    logic [31:0] fetch_rdata;
    logic        req_valid;
    logic        req_ready;
    local_mem_pkg::data_addr_t req_addr;
    logic        req_rnw;
    logic [3:0]  req_be;
    logic [31:0] req_wdata;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        write_uart;
    logic [7:0]  uart_byte;

    int value_errors = 0;
    int timeout_errors = 0;
    int protocol_errors = 0;
    int seed = 32'h338c_4095;

    // reference memory, only written lines exist
    logic [31:0] ref_mem [int];
    entry_t      table_q [$];

    local_mem_system dut_i (.*);

    `include "local_mem_system_tb_tasks.svh"

    always #5 clk = ~clk;

    function automatic local_mem_pkg::data_addr_t ram_addr(input int line);
        local_mem_pkg::data_addr_t a;
        a = '0;
        a.ram_view.line = local_mem_pkg::LINE_W'(line);
        return a;
    endfunction

    function automatic local_mem_pkg::data_addr_t io_addr(input int offset);
        local_mem_pkg::data_addr_t a;
        a = '0;
        a.io_view.region = 1'b1;
        a.io_view.offset = 14'(offset);
        return a;
    endfunction

    // append an entry, the reference model tracks writes in table order
    function automatic void add_entry(input string name, input kind_t kind,
                                      input local_mem_pkg::data_addr_t addr,
                                      input logic [3:0] be, input logic [31:0] wdata);
        entry_t e;
        int     line;
        logic [31:0] word;
        line = int'(addr.ram_view.line);
        e.name = name;
        e.kind = kind;
        e.addr = addr;
        e.be = be;
        e.wdata = wdata;
        e.exp_word = '0;
        case (kind)
            K_WRITE: begin
                word = ref_mem.exists(line) ? ref_mem[line] : 32'd0;
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) word[i*8 +: 8] = wdata[i*8 +: 8];
                end
                ref_mem[line] = word;
            end
            K_READ, K_FETCH: e.exp_word = ref_mem[line];
            K_IO_READ: e.exp_word = 32'hFFFFFF21;
            default: e.exp_word = '0;
        endcase
        table_q.push_back(e);
    endfunction

    task automatic apply_entry(input entry_t e);
        bit          ok;
        bit          got;
        bit          uart_seen;
        bit          is_io;
        bit          uart_due;
        int          cycles;
        logic [31:0] data;
        logic [7:0]  ub;
        is_io = (e.kind == K_IO_READ) || (e.kind == K_IO_WRITE);
        if (e.kind == K_FETCH) begin
            do_fetch(e.name, e.addr, e.exp_word);
        end else begin
            send_data(e.addr, e.kind == K_READ || e.kind == K_IO_READ, e.be, e.wdata, ok);
            if (ok) begin
                wait_resp(is_io, cycles, data, got, uart_seen, ub);
                if (got) begin
                    check_latency(e.name, is_io ? 6 : 1, cycles);
                    check_word(e.name, e.addr, e.exp_word, data);
                end
                // strobe only for writes that hit the uart register
                uart_due = (e.kind == K_IO_WRITE) && (e.addr.io_view.offset == 14'd4096);
                if (uart_due && !uart_seen) begin
                    $display("%s: the uart write produced no strobe", e.name);
                    protocol_errors++;
                end else if (!uart_due && uart_seen) begin
                    $display("%s: an unexpected uart strobe appeared", e.name);
                    protocol_errors++;
                end else if (uart_due) begin
                    check_uart(e.name, e.addr, e.wdata[7:0], ub);
                end
            end
        end
    endtask

    // back to back memory reads, one accepted per cycle
    task automatic read_burst(input int lines [4]);
        @(negedge clk);
        req_valid = 1'b1;
        req_rnw   = 1'b1;
        req_be    = 4'hf;
        req_addr  = ram_addr(lines[0]);
        for (int i = 0; i < 4; i++) begin
            #1;
            if (!req_ready) begin
                $display("burst read %0d was not accepted on its cycle", i);
                protocol_errors++;
            end
            @(posedge clk);
            @(negedge clk);
            if (!resp_valid) begin
                $display("burst read %0d had no response one cycle later", i);
                protocol_errors++;
            end else begin
                check_word("read burst", ram_addr(lines[i]), ref_mem[lines[i]], resp_rdata);
            end
            if (i < 3) req_addr = ram_addr(lines[i+1]);
            else req_valid = 1'b0;
        end
    endtask

    // pipelined fetches on consecutive cycles
    task automatic fetch_burst(input int lines [4]);
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_addr  = ram_addr(lines[0]);
        for (int i = 0; i < 4; i++) begin
            #1;
            if (!fetch_ready) begin
                $display("burst fetch %0d was not accepted on its cycle", i);
                protocol_errors++;
            end
            @(posedge clk);
            @(negedge clk);
            if (!fetch_rvalid) begin
                $display("burst fetch %0d had no data one cycle later", i);
                protocol_errors++;
            end else begin
                check_word("fetch burst", ram_addr(lines[i]), ref_mem[lines[i]], fetch_rdata);
            end
            if (i < 3) fetch_addr = ram_addr(lines[i+1]);
            else fetch_valid = 1'b0;
        end
    endtask

    // memory read queued behind an io read, responses must stay in order
    task automatic io_then_mem(input int line);
        bit          ok;
        bit          taken;
        int          waited;
        logic [31:0] seen [$];
        send_data(io_addr(16), 1'b1, 4'hf, 32'd0, ok);
        @(negedge clk);
        req_addr = ram_addr(line);
        taken    = 1'b0;
        waited   = 0;
        while (ok && seen.size() < 2 && waited < TIMEOUT) begin
            if (resp_valid) seen.push_back(resp_rdata);
            if (taken) req_valid = 1'b0;
            #1;
            if (req_valid && req_ready) taken = 1'b1;
            @(negedge clk);
            waited++;
        end
        req_valid = 1'b0;
        if (seen.size() < 2) begin
            $display("timeout: io read and the following memory read did not both respond");
            timeout_errors++;
        end else begin
            check_word("ordered io response", io_addr(16), 32'hFFFFFF21, seen[0]);
            check_word("ordered mem response", ram_addr(line), ref_mem[line], seen[1]);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr = '0;
        req_valid = 1'b0;
        req_addr = '0;
        req_rnw = 1'b1;
        req_be = 4'h0;
        req_wdata = '0;

        add_entry("write line 5", K_WRITE, ram_addr(5), 4'hf, $random(seed));
        add_entry("write line 6", K_WRITE, ram_addr(6), 4'hf, $random(seed));
        add_entry("write line 7", K_WRITE, ram_addr(7), 4'hf, $random(seed));
        add_entry("write line 4095", K_WRITE, ram_addr(4095), 4'hf, $random(seed));
        add_entry("read line 5", K_READ, ram_addr(5), 4'hf, '0);
        add_entry("read line 4095", K_READ, ram_addr(4095), 4'hf, '0);
        add_entry("partial write line 6", K_WRITE, ram_addr(6), 4'b0101, $random(seed));
        add_entry("partial write line 7", K_WRITE, ram_addr(7), 4'b1000, $random(seed));
        add_entry("read line 6", K_READ, ram_addr(6), 4'hf, '0);
        add_entry("read line 7", K_READ, ram_addr(7), 4'hf, '0);
        add_entry("fetch line 6", K_FETCH, ram_addr(6), 4'hf, '0);
        add_entry("fetch line 4095", K_FETCH, ram_addr(4095), 4'hf, '0);
        add_entry("io read", K_IO_READ, io_addr(16), 4'hf, '0);
        add_entry("uart write", K_IO_WRITE, io_addr(4096), 4'hf, $random(seed));
        add_entry("io write elsewhere", K_IO_WRITE, io_addr(32), 4'hf, $random(seed));

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (table_q[i]) apply_entry(table_q[i]);
        read_burst('{5, 6, 7, 4095});
        fetch_burst('{4095, 7, 6, 5});
        io_then_mem(7);

        $display("errors: %0d value, %0d timeout, %0d protocol",
                 value_errors, timeout_errors, protocol_errors);
        if (value_errors + timeout_errors + protocol_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* logic/local_mem_system.sv */
`timescale 1ns/1ps

module local_mem_system (
    input  logic        clk,
    input  logic        rst,

    // instruction fetch port
    input  logic        fetch_valid,
    output logic        fetch_ready,
    input  local_mem_pkg::data_addr_t fetch_addr,
    output logic        fetch_rvalid,
    output logic [31:0] fetch_rdata,

    // data port
    input  logic        req_valid,
    output logic        req_ready,
    input  local_mem_pkg::data_addr_t req_addr,
    input  logic        req_rnw,
    input  logic [3:0]  req_be,
    input  logic [31:0] req_wdata,
    output logic        resp_valid,
    output logic [31:0] resp_rdata,

    // uart capture
    output logic        write_uart,
    output logic [7:0]  uart_byte
);

    logic        fetch_en;

    // router to memory port b
    logic        mem_en;
    logic        mem_we;
    logic [local_mem_pkg::LINE_W-1:0] mem_line;
    logic [3:0]  mem_be;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;

    // router to io target
    logic        io_valid;
    logic        io_ready;
    logic        io_rnw;
    logic [13:0] io_offset;
    logic [31:0] io_wdata;
    logic        io_resp_valid;
    logic [31:0] io_resp_data;

    // fetch side
    // port a never stalls, so ready rises once reset is gone
    assign fetch_en = fetch_valid && fetch_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_ready  <= 1'b0;
            fetch_rvalid <= 1'b0;
        end else begin
            fetch_ready  <= 1'b1;
            // data lands with the memory's registered read
            fetch_rvalid <= fetch_en;
        end
    end

    local_mem mem_i (
        .clk     (clk),
        .rst     (rst),
        .a_en    (fetch_en),
        .a_line  (fetch_addr.ram_view.line),
        .a_rdata (fetch_rdata),
        .b_en    (mem_en),
        .b_we    (mem_we),
        .b_line  (mem_line),
        .b_be    (mem_be),
        .b_wdata (mem_wdata),
        .b_rdata (mem_rdata)
    );

    io_bus_responder io_i (
        .clk           (clk),
        .rst           (rst),
        .io_valid      (io_valid),
        .io_ready      (io_ready),
        .io_rnw        (io_rnw),
        .io_offset     (io_offset),
        .io_wdata      (io_wdata),
        .io_resp_valid (io_resp_valid),
        .io_resp_data  (io_resp_data),
        .write_uart    (write_uart),
        .uart_byte     (uart_byte)
    );

    data_request_router router_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_addr      (req_addr),
        .req_rnw       (req_rnw),
        .req_be        (req_be),
        .req_wdata     (req_wdata),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .mem_en        (mem_en),
        .mem_we        (mem_we),
        .mem_line      (mem_line),
        .mem_be        (mem_be),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .io_valid      (io_valid),
        .io_ready      (io_ready),
        .io_rnw        (io_rnw),
        .io_offset     (io_offset),
        .io_wdata      (io_wdata),
        .io_resp_valid (io_resp_valid),
        .io_resp_data  (io_resp_data)
    );

endmodule

/* logic/data_request_router.sv */
`timescale 1ns/1ps

module data_request_router (
    input  logic        clk,
    input  logic        rst,

    // data port from the core
    input  logic        req_valid,
    output logic        req_ready,
    input  local_mem_pkg::data_addr_t req_addr,
    input  logic        req_rnw,
    input  logic [3:0]  req_be,
    input  logic [31:0] req_wdata,
    output logic        resp_valid,
    output logic [31:0] resp_rdata,

    // local memory, port b
    output logic        mem_en,
    output logic        mem_we,
    output logic [local_mem_pkg::LINE_W-1:0] mem_line,
    output logic [3:0]  mem_be,
    output logic [31:0] mem_wdata,
    input  logic [31:0] mem_rdata,

    // io target
    output logic        io_valid,
    input  logic        io_ready,
    output logic        io_rnw,
    output logic [13:0] io_offset,
    output logic [31:0] io_wdata,
    input  logic        io_resp_valid,
    input  logic [31:0] io_resp_data
);

    logic is_io;
    logic accept;

    // io request outstanding
    logic io_busy;
    // io_busy with the response cycle itself treated as free
    logic io_hold;
    logic io_rd_q;

    // memory result due next cycle, and whether it was a read
    logic mem_pending;
    logic mem_pending_rd;

    // region decode, bit 31
    assign is_io = req_addr.io_view.region;

    // io slot frees up in the response cycle
    assign io_hold = io_busy && !io_resp_valid;

    // io needs an empty memory pipeline and a ready target,
    // memory requests only wait for outstanding io
    assign req_ready = !io_hold && !(is_io && (mem_pending || !io_ready));
    assign accept    = req_valid && req_ready;

    // memory view of the request
    assign mem_en    = accept && !is_io;
    assign mem_we    = !req_rnw;
    assign mem_line  = req_addr.ram_view.line;
    assign mem_be    = req_be;
    assign mem_wdata = req_wdata;

    // io view of the request
    // valid held back while io or memory is still in flight
    assign io_valid  = req_valid && is_io && !io_hold && !mem_pending;
    assign io_rnw    = req_rnw;
    assign io_offset = req_addr.io_view.offset;
    assign io_wdata  = req_wdata;

    // pending tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            io_busy        <= 1'b0;
            io_rd_q        <= 1'b0;
            mem_pending    <= 1'b0;
            mem_pending_rd <= 1'b0;
        end else begin
            // memory result always one cycle out
            mem_pending    <= mem_en;
            mem_pending_rd <= mem_en && req_rnw;

            if (io_valid && io_ready) begin
                io_busy <= 1'b1;
                io_rd_q <= io_rnw;
            end else if (io_resp_valid) begin
                io_busy <= 1'b0;
            end
        end
    end

    // response merge
    // the two sources never overlap, memory wins by construction
    assign resp_valid = mem_pending || io_resp_valid;

    always_comb begin
        resp_rdata = 32'd0;
        if (mem_pending) begin
            // writes return zero
            if (mem_pending_rd) begin
                resp_rdata = mem_rdata;
            end
        end else if (io_resp_valid && io_rd_q) begin
            resp_rdata = io_resp_data;
        end
    end

endmodule

/* logic/io_bus_responder.sv */
`timescale 1ns/1ps

module io_bus_responder (
    input  logic        clk,
    input  logic        rst,

    // request side
    input  logic        io_valid,
    output logic        io_ready,
    input  logic        io_rnw,
    input  logic [13:0] io_offset,
    input  logic [31:0] io_wdata,

    // response side, single cycle pulse
    output logic        io_resp_valid,
    output logic [31:0] io_resp_data,

    // uart capture
    output logic        write_uart,
    output logic [7:0]  uart_byte
);

    // reload value for the countdown
    // count hits zero one edge before the response is raised
    // the accepting edge is the first cycle of the wait
    localparam logic [3:0] COUNT_LOAD = 4'(local_mem_pkg::IO_LATENCY - 2);

    logic       accept;
    logic [3:0] count;

    // latched request fields
    logic       rnw_q;
    logic       uart_hit_q;
    logic [7:0] byte_q;

    assign accept = io_valid && io_ready;

    // control
    // starts out ready, one request at a time
    always_ff @(posedge clk) begin
        if (rst) begin
            io_ready      <= 1'b1;
            io_resp_valid <= 1'b0;
            write_uart    <= 1'b0;
            count         <= '0;
        end else begin
            // response and uart strobe last one cycle
            io_resp_valid <= 1'b0;
            write_uart    <= 1'b0;

            if (accept) begin
                io_ready <= 1'b0;
                count    <= COUNT_LOAD;
            end else if (!io_ready) begin
                if (count == '0) begin
                    // wait done, answer and take the next request
                    io_resp_valid <= 1'b1;
                    io_ready      <= 1'b1;
                    // strobe only for a write that hit the uart register
                    write_uart    <= uart_hit_q;
                end else begin
                    count <= count - 4'd1;
                end
            end
        end
    end

    // request payload, captured on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            rnw_q      <= io_rnw;
            // writes elsewhere in the window are acked and dropped
            uart_hit_q <= !io_rnw && (io_offset == 14'(local_mem_pkg::UART_OFFSET));
            byte_q     <= io_wdata[7:0];
        end
    end

    // response payload, loaded with the response pulse
    always_ff @(posedge clk) begin
        if (!io_ready && count == '0) begin
            // fixed idle pattern on reads, zero on writes
            io_resp_data <= rnw_q ? local_mem_pkg::IO_READ_VALUE : 32'd0;
            uart_byte    <= byte_q;
        end
    end

endmodule

/* logic/local_mem.sv */
`timescale 1ns/1ps

module local_mem (
    input  logic        clk,
    input  logic        rst,

    // port a, instruction fetch, read only
    input  logic        a_en,
    input  logic [local_mem_pkg::LINE_W-1:0] a_line,
    output logic [31:0] a_rdata,

    // port b, data side, read or byte-lane write
    input  logic        b_en,
    input  logic        b_we,
    input  logic [local_mem_pkg::LINE_W-1:0] b_line,
    input  logic [3:0]  b_be,
    input  logic [31:0] b_wdata,
    output logic [31:0] b_rdata
);

    // word array, one entry per line
    logic [31:0] mem [local_mem_pkg::MEM_LINES];

    // port a
    // registered read, result one cycle after a_en
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_rdata <= mem[a_line];
        end
    end

    // port b
    // read and write share the enable
    // nonblocking update, so a read of the line being written sees old data
    always_ff @(posedge clk) begin
        if (b_en) begin
            b_rdata <= mem[b_line];
            // no stores while reset is held
            if (b_we && !rst) begin
                // only enabled byte lanes change
                for (int i = 0; i < 4; i++) begin
                    if (b_be[i]) begin
                        mem[b_line][i*8 +: 8] <= b_wdata[i*8 +: 8];
                    end
                end
            end
        end
    end

    // port a also sees old data when port b writes the same line,
    // since both reads sample the array before the write lands

endmodule

/* logic/local_mem_pkg.sv */
package local_mem_pkg;

    // local memory geometry
    // 4096 words of 32 bits, 16 KB in all
    localparam int MEM_LINES = 4096;

    // word index width, log2 of MEM_LINES
    localparam int LINE_W = 12;

    // io target timing
    // cycles from request acceptance to the response pulse
    localparam int IO_LATENCY = 6;

    // uart transmit register, offset inside the io window
    localparam int UART_OFFSET = 4096;

    // pattern the slow target returns on every read
    localparam logic [31:0] IO_READ_VALUE = 32'hFFFFFF21;

    // data side address, decoded two ways by the router
    // bit 31 picks the region in both views: 0 local memory, 1 io
    typedef union packed {
        // local memory view
        struct packed {
            logic              region;
            logic [16:0]       unused;
            // word index into the memory array
            logic [LINE_W-1:0] line;
            // byte inside the word, lanes come from the byte enables
            logic [1:0]        byte_off;
        } ram_view;

        // peripheral view
        struct packed {
            logic        region;
            logic [16:0] unused;
            // register offset seen by the io target
            logic [13:0] offset;
        } io_view;
    } data_addr_t;

endpackage
